//--- branch_predictor.f
+incdir+tb
design/rv_isa_pkg.sv
design/bp_cfg_pkg.sv
design/bp_resolve.sv
design/btb.sv
design/gshare_pht.sv
design/branch_predictor.sv
tb/tb_branch_predictor.sv

//--- Makefile
# Verilator build and run for the branch predictor testbench

VERILATOR ?= verilator
TOP       ?= tb_branch_predictor
FILELIST  ?= branch_predictor.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?=

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The run passes only when the pass line shows up in the output
run: compile
	@out="$$(./$(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "TB PASSED"; then \
		exit 0; \
	else \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)

//--- tb/bp_model.svh
// Shadow predictor for the testbench; include inside a module that imports both packages
`ifndef BP_MODEL_SVH
`define BP_MODEL_SVH

logic  m_valid   [BTB_ENTRIES];
addr_t m_tag     [BTB_ENTRIES];
addr_t m_target  [BTB_ENTRIES];
logic  m_is_jump [BTB_ENTRIES];   // Else a branch
ctr_t  m_pht     [2**GHR_W];
ghr_t  m_ghr;

function automatic cf_kind_e decode_kind(input opcode_t op);
    if (op == OP_JAL || op == OP_JALR)
        return CF_JUMP;
    if (op == OP_BRANCH)
        return CF_BRANCH;
    return CF_NONE;
endfunction

task automatic reset_tables();
    for (int i = 0; i < BTB_ENTRIES; i++) begin
        m_valid[i] = 1'b0;
    end
    for (int i = 0; i < 2**GHR_W; i++) begin
        m_pht[i] = 2'b01;   // Weakly not taken
    end
    m_ghr = '0;
endtask

// Direction comes from the counter at PC XOR history, only for a BTB hit
function automatic pred_t predict_pc(input addr_t pc);
    pred_t    p;
    btb_idx_t bi;
    ghr_t     pi;
    bi       = pc[BTB_IDX_W+1:2];
    pi       = pc[GHR_W+1:2] ^ m_ghr;
    p.hit    = m_valid[bi] && (m_tag[bi] == pc);
    p.taken  = p.hit && (m_is_jump[bi] || m_pht[pi][1]);
    p.target = p.hit ? m_target[bi] : 32'h0;
    return p;
endfunction

function automatic logic mispredict_rule(input resolve_t r);
    if (!r.valid)
        return 1'b0;
    return (r.taken != r.pred_taken) || (r.taken && (r.target != r.pred_target));
endfunction

task automatic apply_resolve(input resolve_t r, input logic clr);
    cf_kind_e k;
    btb_idx_t bi;
    ghr_t     pi;
    k  = decode_kind(r.opcode);
    bi = r.pc[BTB_IDX_W+1:2];
    pi = r.pc[GHR_W+1:2] ^ m_ghr;   // History before this outcome
    if (r.valid && (k == CF_JUMP || (k == CF_BRANCH && r.taken))) begin
        m_valid[bi]   = 1'b1;
        m_tag[bi]     = r.pc;
        m_target[bi]  = r.target;
        m_is_jump[bi] = (k == CF_JUMP);
    end
    if (r.valid && k == CF_BRANCH) begin
        if (r.taken && m_pht[pi] != 2'b11)
            m_pht[pi] = m_pht[pi] + 2'b01;
        else if (!r.taken && m_pht[pi] != 2'b00)
            m_pht[pi] = m_pht[pi] - 2'b01;
        m_ghr = {m_ghr[GHR_W-2:0], r.taken};
    end
    if (clr)
        m_ghr = '0;   // Clear beats the shift
endtask

`endif

//--- tb/tb_branch_predictor.sv
// Checks run against the shadow model on every rising edge once reset is released
`timescale 1ns/1ps

module tb_branch_predictor;
    import bp_cfg_pkg::*;
    import rv_isa_pkg::*;

    `include "bp_model.svh"

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 5;
    localparam int SAT_ROUNDS      = 5;
    localparam int HIST_ROUNDS     = 3;
    localparam int N_RAND          = 400;
    localparam int DIRECTED_CYCLES = 8 + 4*SAT_ROUNDS + 2*HIST_ROUNDS + 3 + 5 + 5;
    localparam int STIM_CYCLES     = RESET_CYCLES + DIRECTED_CYCLES + N_RAND + 2;

    localparam resolve_t NO_RES = '0;
    localparam addr_t    BR_PC  = 32'h0000_0440;

    logic     clk;
    logic     rst_n;
    addr_t    fetch_pc;
    resolve_t resolve;
    logic     ghr_clear;
    pred_t    pred;
    logic     mispredict;

    pred_t    exp_pred;
    logic     exp_mp;
    int       pred_errs;
    int       mp_errs;
    integer   seed = 16450;

    branch_predictor u_dut (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .fetch_pc_i   (fetch_pc),
        .resolve_i    (resolve),
        .ghr_clear_i  (ghr_clear),
        .pred_o       (pred),
        .mispredict_o (mispredict)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // Model trains on the same edge as the DUT
    always @(posedge clk) begin
        if (!rst_n)
            reset_tables();
        else
            apply_resolve(resolve, ghr_clear);
    end

    a_pred_match: assert property (@(posedge clk) disable iff (!rst_n) pred == exp_pred)
        else begin
            pred_errs++;
            $display("Error: %0t ns, pc %h pred %h expected %h", $time, fetch_pc, pred, exp_pred);
        end

    a_mp_match: assert property (@(posedge clk) disable iff (!rst_n) mispredict == exp_mp)
        else begin
            mp_errs++;
            $display("Error: %0t ns, mispredict %b expected %b", $time, mispredict, exp_mp);
        end

    a_miss_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !pred.hit |-> (!pred.taken && pred.target == '0))
        else begin
            pred_errs++;
            $display("Error: %0t ns, miss with taken %b target %h", $time, pred.taken, pred.target);
        end

    function automatic resolve_t make_res(input logic v, input addr_t pc, input opcode_t op,
                                          input logic tk, input addr_t tgt,
                                          input logic ptk, input addr_t ptgt);
        resolve_t r;
        r.valid       = v;
        r.pc          = pc;
        r.opcode      = op;
        r.taken       = tk;
        r.target      = tgt;
        r.pred_taken  = ptk;
        r.pred_target = ptgt;
        return r;
    endfunction

    // One cycle of stimulus, applied on the falling edge
    task automatic drive(input addr_t pc, input resolve_t res, input logic clr);
        @(negedge clk);
        fetch_pc  = pc;
        resolve   = res;
        ghr_clear = clr;
        exp_pred  = predict_pc(pc);
        exp_mp    = mispredict_rule(res);
    endtask

    task automatic train_jumps();
        drive(32'h0000_0040, make_res(1, 32'h80, OP_JAL, 1, 32'h2000, 0, 0), 1'b0);
        drive(32'h0000_0080, NO_RES, 1'b0);
        drive(32'h0000_0040, make_res(1, 32'h84, OP_JALR, 1, 32'h3000, 1, 32'h3000), 1'b0);
        drive(32'h0000_0084, NO_RES, 1'b0);
    endtask

    // Clearing with each resolve pins the history at zero
    task automatic saturate_branch(input logic tk);
        for (int i = 0; i < SAT_ROUNDS; i++) begin
            drive(BR_PC, make_res(1, BR_PC, OP_BRANCH, tk, 32'h800, 0, 0), 1'b1);
            drive(BR_PC, NO_RES, 1'b0);
        end
    endtask

    task automatic walk_history();
        // Zero-history counter ends weakly taken, so the clear below shows up
        drive(BR_PC, make_res(1, BR_PC, OP_BRANCH, 1, 32'h800, 1, 32'h800), 1'b1);
        for (int i = 0; i < HIST_ROUNDS; i++) begin
            drive(BR_PC, make_res(1, BR_PC, OP_BRANCH, 1, 32'h800, 1, 32'h800), 1'b0);
            drive(BR_PC, NO_RES, 1'b0);
        end
        drive(BR_PC, NO_RES, 1'b1);
        drive(BR_PC, NO_RES, 1'b0);
    endtask

    task automatic alias_entries();
        addr_t pc_a;
        addr_t pc_b;
        pc_a = 32'h0000_0300;
        pc_b = pc_a + BTB_ENTRIES * 4;   // Same index, other tag
        drive(32'h0, make_res(1, pc_a, OP_JAL, 1, 32'h4000, 0, 0), 1'b0);
        drive(pc_a, NO_RES, 1'b0);
        drive(pc_a, make_res(1, pc_b, OP_JAL, 1, 32'h4800, 0, 0), 1'b0);
        drive(pc_b, NO_RES, 1'b0);
        drive(pc_a, NO_RES, 1'b0);
    endtask

    task automatic probe_mispredict();
        drive(32'h0, make_res(1, BR_PC, OP_BRANCH, 1, 32'h800, 0, 0), 1'b0);         // Direction
        drive(32'h0, make_res(1, 32'h200, OP_JAL, 1, 32'h5000, 1, 32'h5004), 1'b0);  // Target
        drive(32'h0, make_res(0, BR_PC, OP_BRANCH, 1, 32'h800, 0, 0), 1'b0);
        drive(32'h0, make_res(1, BR_PC, OP_BRANCH, 0, 32'h800, 0, 32'h123c), 1'b0);
        drive(32'h0, make_res(1, 32'h208, 7'b0010011, 0, 0, 1, 0), 1'b0);
    endtask

    task automatic run_random(input int n);
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        opcode_t     op;
        logic        tk;
        addr_t       tgt;
        for (int i = 0; i < n; i++) begin
            r0 = $random(seed);
            r1 = $random(seed);
            r2 = $random(seed);
            case (r1[2:0])
                3'd2:    op = OP_JAL;
                3'd3:    op = OP_JALR;
                3'd7:    op = 7'b0110011;
                default: op = OP_BRANCH;
            endcase
            tk  = (op == OP_JAL || op == OP_JALR) ? 1'b1 : r1[5];
            tgt = {20'h00002, r2[9:0], 2'b00};
            drive({24'h000001, r0[5:0], 2'b00},
                  make_res(r1[3] | r1[4], {24'h000001, r0[11:6], 2'b00}, op, tk, tgt,
                           r1[6], r1[7] ? tgt : {20'h00003, r2[19:10], 2'b00}),
                  r1[11:8] == 4'h0);
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        fetch_pc  = '0;
        resolve   = NO_RES;
        ghr_clear = 1'b0;
        exp_pred  = '0;
        exp_mp    = 1'b0;
        pred_errs = 0;
        mp_errs   = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        drive(32'h0000_0000, NO_RES, 1'b0);   // Nothing may hit yet
        drive(32'h0000_0080, NO_RES, 1'b0);
        drive(32'h0000_0440, NO_RES, 1'b0);
        drive(32'hffff_fffc, NO_RES, 1'b0);
        train_jumps();
        saturate_branch(1'b1);
        saturate_branch(1'b0);
        walk_history();
        alias_entries();
        probe_mispredict();
        run_random(N_RAND);
        drive(32'h0, NO_RES, 1'b0);
        @(posedge clk);
        @(negedge clk);

        $display("Checks done: %0d prediction errors, %0d mispredict errors", pred_errs, mp_errs);
        if (pred_errs + mp_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * (STIM_CYCLES + 50));
        $display("Watchdog expired before the stimulus finished");
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- design/branch_predictor.sv
// Next-PC predictor top; zero-cycle lookup, training lands on the edge after the resolve strobe
`timescale 1ns/1ps

module branch_predictor (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  bp_cfg_pkg::addr_t    fetch_pc_i,
    input  bp_cfg_pkg::resolve_t resolve_i,
    input  logic                 ghr_clear_i,
    output bp_cfg_pkg::pred_t    pred_o,
    output logic                 mispredict_o
);
    import bp_cfg_pkg::*;

    btb_wr_t  btb_wr;
    pht_upd_t pht_upd;
    logic     dir_taken;

    bp_resolve u_resolve (
        .resolve_i    (resolve_i),
        .btb_wr_o     (btb_wr),
        .pht_upd_o    (pht_upd),
        .mispredict_o (mispredict_o)
    );

    btb u_btb (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .lookup_pc_i (fetch_pc_i),
        .dir_taken_i (dir_taken),
        .wr_i        (btb_wr),
        .pred_o      (pred_o)
    );

    gshare_pht u_pht (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .lookup_pc_i (fetch_pc_i),
        .upd_i       (pht_upd),
        .ghr_clear_i (ghr_clear_i),
        .dir_taken_o (dir_taken)
    );

    // A resolved write is visible to fetch from the very next cycle
    a_wr_visible: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (btb_wr.we ##1 (fetch_pc_i == $past(btb_wr.pc)))
            |-> (pred_o.hit && (pred_o.target == $past(btb_wr.target)))
    ) else $error("BTB write at pc %h not seen by next lookup", fetch_pc_i);

endmodule

//--- design/gshare_pht.sv
// Gshare PHT; the GHR moves only on resolved branches, no speculative update or repair
`timescale 1ns/1ps

module gshare_pht (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  bp_cfg_pkg::addr_t    lookup_pc_i,
    input  bp_cfg_pkg::pht_upd_t upd_i,
    input  logic                 ghr_clear_i,
    output logic                 dir_taken_o
);
    import bp_cfg_pkg::*;

    ghr_t                   ghr_q;
    ctr_t [2**GHR_W-1:0]    pht_q;

    ghr_t rd_idx;
    ghr_t upd_idx;
    ctr_t upd_ctr;
    ctr_t upd_ctr_next;

    // Same hash for lookup and training, both against the current GHR
    assign rd_idx  = lookup_pc_i[GHR_W+1:2] ^ ghr_q;
    assign upd_idx = upd_i.pc[GHR_W+1:2] ^ ghr_q;

    assign dir_taken_o = pht_q[rd_idx][1];   // MSB of the counter

    // Saturating step
    always_comb begin
        upd_ctr      = pht_q[upd_idx];
        upd_ctr_next = upd_ctr;
        if (upd_i.taken) begin
            if (upd_ctr != CTR_MAX)
                upd_ctr_next = upd_ctr + 2'd1;
        end else begin
            if (upd_ctr != CTR_MIN)
                upd_ctr_next = upd_ctr - 2'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 2**GHR_W; i++) begin
                pht_q[i] <= CTR_RESET;
            end
        end else if (upd_i.we) begin
            pht_q[upd_idx] <= upd_ctr_next;
        end
    end

    // Clear wins over a shift in the same cycle
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ghr_q <= '0;
        end else if (ghr_clear_i) begin
            ghr_q <= '0;
        end else if (upd_i.we) begin
            ghr_q <= {ghr_q[GHR_W-2:0], upd_i.taken};
        end
    end

    a_state_known: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !$isunknown(ghr_q) && !$isunknown(pht_q)
    ) else $error("GHR or PHT holds unknown bits");

endmodule

//--- design/btb.sv
// Direct-mapped BTB with full-PC tags; no write-to-read bypass, so a same-cycle write is unseen
`timescale 1ns/1ps

module btb (
    input  logic                clk,
    input  logic                rst_n_i,
    input  bp_cfg_pkg::addr_t   lookup_pc_i,
    input  logic                dir_taken_i,
    input  bp_cfg_pkg::btb_wr_t wr_i,
    output bp_cfg_pkg::pred_t   pred_o
);
    import bp_cfg_pkg::*;
    import rv_isa_pkg::*;

    typedef struct packed {
        addr_t    tag;
        addr_t    target;
        cf_kind_e kind;
    } btb_entry_t;

    btb_entry_t                entry_q [BTB_ENTRIES];
    logic [BTB_ENTRIES-1:0]    valid_q;

    btb_idx_t   rd_idx;
    btb_idx_t   wr_idx;
    btb_entry_t rd_entry;
    logic       hit;
    logic       taken;

    assign rd_idx = lookup_pc_i[BTB_IDX_W+1:2];
    assign wr_idx = wr_i.pc[BTB_IDX_W+1:2];

    // Valid bits are the only state cleared by reset
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (wr_i.we) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Entry payload, replaces whatever lived at this index
    always_ff @(posedge clk) begin
        if (wr_i.we) begin
            entry_q[wr_idx].tag    <= wr_i.pc;
            entry_q[wr_idx].target <= wr_i.target;
            entry_q[wr_idx].kind   <= wr_i.kind;
        end
    end

    assign rd_entry = entry_q[rd_idx];
    assign hit      = valid_q[rd_idx] && (rd_entry.tag == lookup_pc_i);

    // Jumps always go, branches follow the PHT direction
    always_comb begin
        taken = 1'b0;
        if (hit) begin
            case (rd_entry.kind)
                CF_JUMP:   taken = 1'b1;
                CF_BRANCH: taken = dir_taken_i;
                default:   taken = 1'b0;
            endcase
        end
    end

    always_comb begin
        pred_o.hit    = hit;
        pred_o.taken  = taken;
        pred_o.target = hit ? rd_entry.target : '0;
    end

    // Resolve must only write real control instructions
    a_wr_kind: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        wr_i.we |-> (wr_i.kind != CF_NONE)
    ) else $error("BTB write with kind CF_NONE at pc %h", wr_i.pc);

    // Targets come from execute; an unaligned one means a corrupt write path
    a_hit_aligned: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        pred_o.hit |-> (pred_o.target[1:0] == 2'b00)
    ) else $error("BTB hit with unaligned target %h", pred_o.target);

endmodule

//--- design/bp_resolve.sv
// Resolve decode uses the opcode only; a taken target is trusted as computed by execute
`timescale 1ns/1ps

module bp_resolve (
    input  bp_cfg_pkg::resolve_t resolve_i,
    output bp_cfg_pkg::btb_wr_t  btb_wr_o,
    output bp_cfg_pkg::pht_upd_t pht_upd_o,
    output logic                 mispredict_o
);
    import rv_isa_pkg::*;

    cf_kind_e kind;
    logic     is_jump;
    logic     is_branch;
    logic     dir_wrong;
    logic     tgt_wrong;

    always_comb begin
        case (resolve_i.opcode)
            OP_JAL,
            OP_JALR:   kind = CF_JUMP;
            OP_BRANCH: kind = CF_BRANCH;
            default:   kind = CF_NONE;
        endcase
    end

    assign is_jump   = resolve_i.valid && (kind == CF_JUMP);
    assign is_branch = resolve_i.valid && (kind == CF_BRANCH);

    // Not-taken branches are left out of the BTB
    always_comb begin
        btb_wr_o.we     = is_jump || (is_branch && resolve_i.taken);
        btb_wr_o.pc     = resolve_i.pc;
        btb_wr_o.target = resolve_i.target;
        btb_wr_o.kind   = kind;
    end

    // Only conditional branches train direction and history
    always_comb begin
        pht_upd_o.we    = is_branch;
        pht_upd_o.pc    = resolve_i.pc;
        pht_upd_o.taken = resolve_i.taken;
    end

    assign dir_wrong = (resolve_i.taken != resolve_i.pred_taken);
    assign tgt_wrong = resolve_i.taken && (resolve_i.target != resolve_i.pred_target);

    always_comb begin
        mispredict_o = resolve_i.valid && (dir_wrong || tgt_wrong);
        // A stale record left on the bus must never redirect fetch
        a_mp_valid: assert (!mispredict_o || resolve_i.valid)
            else $error("Mispredict raised without a valid resolve");
    end

endmodule

//--- design/bp_cfg_pkg.sv
// Predictor sizes are fixed here; PC bits [1:0] are assumed zero (RV32I without compressed)
package bp_cfg_pkg;

    localparam int BTB_ENTRIES = 32;
    localparam int BTB_IDX_W   = $clog2(BTB_ENTRIES);
    localparam int GHR_W       = 5;             // Also the PHT index width

    typedef logic [31:0]          addr_t;
    typedef logic [BTB_IDX_W-1:0] btb_idx_t;    // PC bits above bit 1
    typedef logic [GHR_W-1:0]     ghr_t;
    typedef logic [1:0]           ctr_t;

    // Counter encodings
    localparam ctr_t CTR_MIN   = 2'b00;
    localparam ctr_t CTR_RESET = 2'b01;         // Weakly not taken
    localparam ctr_t CTR_MAX   = 2'b11;

    typedef struct packed {
        logic  hit;
        logic  taken;
        addr_t target;                          // Zero on a miss
    } pred_t;

    // Outcome from execute, valid is a one-cycle strobe
    typedef struct packed {
        logic                 valid;
        addr_t                pc;
        rv_isa_pkg::opcode_t  opcode;
        logic                 taken;
        addr_t                target;
        logic                 pred_taken;
        addr_t                pred_target;
    } resolve_t;

    typedef struct packed {
        logic                 we;
        addr_t                pc;
        addr_t                target;
        rv_isa_pkg::cf_kind_e kind;
    } btb_wr_t;

    typedef struct packed {
        logic  we;
        addr_t pc;
        logic  taken;
    } pht_upd_t;

endpackage

//--- design/rv_isa_pkg.sv
// Only the RV32I control-transfer opcodes are listed; funct3 is not decoded
package rv_isa_pkg;

    typedef logic [6:0] opcode_t;

    // Major opcodes, bits [6:0] of the instruction
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;   // BEQ BNE BLT BGE BLTU BGEU

    // Kind of control instruction, as kept in the BTB
    // JAL and JALR both count as unconditional jumps
    typedef enum logic [1:0] {
        CF_NONE   = 2'd0,
        CF_JUMP   = 2'd1,
        CF_BRANCH = 2'd2
    } cf_kind_e;

endpackage
